/* project.f */
+incdir+hdl
hdl/conv_pkg.sv
hdl/mul_delay.sv
hdl/beat_decode.sv
hdl/pe_array.sv
hdl/result_stage.sv
hdl/conv_engine_top.sv
tests/tb_clock.sv
tests/tb_conv_engine.sv

/* run.sh */
#!/bin/sh
# Build the testbench and RTL with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"

mkdir -p "$build_dir"
if [ $? -ne 0 ]; then
  echo "could not create $build_dir"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_conv_engine -Mdir "$build_dir/obj" -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$build_dir/obj/Vtb_conv_engine" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -qF '** FAIL **' "$log_file"; then
  echo "failure reported in $log_file"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "no failure found in $log_file"
exit 0

/* tests/tb_conv_engine.sv */
`timescale 1ns/100ps
`include "conv_macros.svh"

module tb_conv_engine;

  localparam int ROWS           = `CONV_ROWS;
  localparam int COLS           = `CONV_COLS;
  localparam int MAX_LEN        = 8;
  localparam int PER_PHASE      = 10;
  localparam int N_PACKETS      = 4 * PER_PHASE;
  localparam int STALL_FACTOR   = 4;
  localparam int TIMEOUT_CYCLES = N_PACKETS * MAX_LEN * STALL_FACTOR + 200;
  localparam int LATENCY        = `CONV_DELAY_MUL + 2;

  logic              clk;
  logic              resetn;
  logic              in_valid;
  conv_pkg::beat_t   in_beat;
  logic              in_ready;
  logic              out_valid;
  conv_pkg::result_t out_result;
  logic              out_ready;

  logic [31:0]       lfsr_q;
  bit                ready_random;
  int                cycle_count;
  conv_pkg::beat_t   cur_beats[MAX_LEN];
  int                cur_len;
  conv_pkg::result_t exp_q[$];
  int                accept_q[$];
  bit                latency_q[$];

  tb_clock #(.RESET_CYCLES(16)) u_clock (
    .clk    (clk),
    .resetn (resetn)
  );

  conv_engine_top DUT (
    .clk        (clk),
    .resetn     (resetn),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_ready  (out_ready)
  );

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  function automatic int random_length();
    logic [31:0] bits;
    bits = take_bits(3);
    return 1 + int'(bits[2:0]);
  endfunction

  // y[c][r] is the sum of pixel[r] * weight[c], wrapped to the accumulator width
  function automatic conv_pkg::result_t reference_result(
    input conv_pkg::beat_t beats[MAX_LEN],
    input int              len
  );
    conv_pkg::result_t res;
    conv_pkg::pixel_t  px;
    conv_pkg::weight_t wt;
    longint            sum;
    res = '0;
    for (int c = 0; c < COLS; c++) begin
      for (int r = 0; r < ROWS; r++) begin
        sum = 0;
        for (int b = 0; b < len; b++) begin
          px = beats[b].pixels[r];
          wt = beats[b].weights[c];
          sum = sum + longint'(px) * longint'(wt);
        end
        res.data[c][r] = sum[`CONV_Y_BITS-1:0];
      end
    end
    res.tag = beats[len-1].tag;
    return res;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_matrix(
    input conv_pkg::acc_matrix_t got,
    input conv_pkg::acc_matrix_t exp
  );
    for (int c = 0; c < COLS; c++) begin
      for (int r = 0; r < ROWS; r++) begin
        if (got[c][r] !== exp[c][r]) begin
          stop_on_error($sformatf("mismatch at %0t: out_result.data[%0d][%0d] got %0d, expected %0d",
                                  $time, c, r, got[c][r], exp[c][r]));
        end
      end
    end
  endtask

  task automatic compare_tag(input conv_pkg::tag_t got, input conv_pkg::tag_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t: out_result.tag got %0h, expected %0h",
                              $time, got, exp));
    end
  endtask

  task automatic compare_latency(input int got, input int exp);
    if (got != exp) begin
      stop_on_error($sformatf("mismatch at %0t: out_valid latency got %0d, expected %0d",
                              $time, got, exp));
    end
  endtask

  // Inputs change 1 ns after the edge, out_ready included
  task automatic next_cycle();
    logic [31:0] bits;
    @(posedge clk);
    #1;
    if (ready_random) begin
      bits = take_bits(1);
      out_ready = bits[0];
    end else begin
      out_ready = 1'b1;
    end
  endtask

  // Hold the beat until the handshake edge has passed
  task automatic wait_accept();
    @(negedge clk);
    while (!in_ready) begin
      next_cycle();
      @(negedge clk);
    end
    next_cycle();
  endtask

  task automatic send_packet(input int len, input bit gaps);
    conv_pkg::beat_t beat;
    conv_pkg::tag_t  tag;
    logic [31:0]     bits;
    bits = take_bits(`CONV_TAG_BITS);
    tag = bits[`CONV_TAG_BITS-1:0];
    for (int b = 0; b < len; b++) begin
      for (int r = 0; r < ROWS; r++) begin
        bits = take_bits(`CONV_X_BITS);
        beat.pixels[r] = bits[`CONV_X_BITS-1:0];
      end
      for (int c = 0; c < COLS; c++) begin
        bits = take_bits(`CONV_K_BITS);
        beat.weights[c] = bits[`CONV_K_BITS-1:0];
      end
      beat.tag  = tag;
      beat.last = (b == len - 1);
      // Idle cycles before about one beat in four
      if (gaps) begin
        bits = take_bits(2);
        while (bits[1:0] == 2'b00) begin
          in_valid = 1'b0;
          next_cycle();
          bits = take_bits(2);
        end
      end
      in_valid = 1'b1;
      in_beat  = beat;
      wait_accept();
    end
    in_valid = 1'b0;
  endtask

  task automatic drain_results();
    in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  task automatic record_beat(input conv_pkg::beat_t beat);
    cur_beats[cur_len] = beat;
    cur_len = cur_len + 1;
    if (beat.last) begin
      exp_q.push_back(reference_result(cur_beats, cur_len));
      accept_q.push_back(cycle_count);
      latency_q.push_back(!ready_random);
      cur_len = 0;
    end
  endtask

  task automatic check_output();
    conv_pkg::result_t exp;
    int                accepted;
    bit                timed;
    if (exp_q.size() == 0) begin
      stop_on_error("an output transfer happened with no packet outstanding");
    end else begin
      exp      = exp_q.pop_front();
      accepted = accept_q.pop_front();
      timed    = latency_q.pop_front();
      compare_matrix(out_result.data, exp.data);
      compare_tag(out_result.tag, exp.tag);
      if (timed) begin
        compare_latency(cycle_count - accepted, LATENCY);
      end
    end
  endtask

  // Scoreboard samples mid-cycle, where every handshake signal is settled
  always @(negedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("timeout: the run did not finish within %0d cycles",
                              TIMEOUT_CYCLES));
    end
    if (resetn) begin
      if (!in_ready && !(out_valid && !out_ready && exp_q.size() >= 2)) begin
        stop_on_error("in_ready dropped while fewer than two results were pending");
      end
      if (in_valid && in_ready) begin
        record_beat(in_beat);
      end
      if (out_valid && out_ready) begin
        check_output();
      end
    end
  end

  initial begin
    lfsr_q       = 32'd69720;
    ready_random = 1'b0;
    in_valid     = 1'b0;
    in_beat      = '0;
    out_ready    = 1'b0;

    @(posedge resetn);
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      stop_on_error("out_valid was high right after reset");
    end
    if (in_ready !== 1'b1) begin
      stop_on_error("in_ready was low right after reset");
    end
    next_cycle();

    // Single beats, consumer always ready, latency checked
    repeat (PER_PHASE) send_packet(1, 1'b0);
    drain_results();

    // Random lengths, still always ready
    repeat (PER_PHASE) send_packet(random_length(), 1'b0);
    drain_results();

    // Back-pressure from a random consumer
    ready_random = 1'b1;
    repeat (PER_PHASE) send_packet(random_length(), 1'b0);
    drain_results();

    // Back-pressure plus gaps in the input stream
    repeat (PER_PHASE) send_packet(random_length(), 1'b1);
    drain_results();

    // Quiet tail, any extra output shows up here
    ready_random = 1'b0;
    repeat (20) next_cycle();

    if (exp_q.size() != 0 || cur_len != 0) begin
      stop_on_error("results were still outstanding at the end of the run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic resetn
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release just after a rising edge, like the other stimulus
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    resetn = 1'b1;
  end

endmodule

/* hdl/conv_engine_top.sv */
`timescale 1ns/100ps

module conv_engine_top (
  input  logic              clk,
  input  logic              resetn,
  input  logic              in_valid,
  input  conv_pkg::beat_t   in_beat,
  output logic              in_ready,
  output logic              out_valid,
  output conv_pkg::result_t out_result,
  input  logic              out_ready
);

  logic                  op_valid;
  conv_pkg::pixel_col_t  op_pixels;
  conv_pkg::weight_row_t op_weights;
  conv_pkg::ctrl_t       op_ctrl;
  logic                  stage_en;
  logic                  acc_valid;
  conv_pkg::acc_matrix_t acc_data;
  conv_pkg::tag_t        acc_tag;
  logic                  buf_free;

  // Decode
  beat_decode u_decode (
    .clk        (clk),
    .resetn     (resetn),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_ready   (in_ready),
    .op_valid   (op_valid),
    .op_pixels  (op_pixels),
    .op_weights (op_weights),
    .op_ctrl    (op_ctrl),
    .stage_en   (stage_en)
  );

  // Execute
  pe_array u_array (
    .clk        (clk),
    .resetn     (resetn),
    .op_valid   (op_valid),
    .op_pixels  (op_pixels),
    .op_weights (op_weights),
    .op_ctrl    (op_ctrl),
    .stage_en   (stage_en),
    .acc_valid  (acc_valid),
    .acc_data   (acc_data),
    .acc_tag    (acc_tag),
    .buf_free   (buf_free)
  );

  // Result
  result_stage u_result (
    .clk        (clk),
    .resetn     (resetn),
    .acc_valid  (acc_valid),
    .acc_data   (acc_data),
    .acc_tag    (acc_tag),
    .buf_free   (buf_free),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_ready  (out_ready)
  );

endmodule

/* hdl/result_stage.sv */
`timescale 1ns/100ps

module result_stage (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  acc_valid,
  input  conv_pkg::acc_matrix_t acc_data,
  input  conv_pkg::tag_t        acc_tag,
  output logic                  buf_free,
  output logic                  out_valid,
  output conv_pkg::result_t     out_result,
  input  logic                  out_ready
);

  logic              full_q;
  conv_pkg::result_t buf_q;

  // Free when empty or draining this cycle
  assign buf_free   = !full_q || out_ready;
  assign out_valid  = full_q;
  assign out_result = buf_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      full_q <= 1'b0;
    end else if (acc_valid) begin
      full_q <= 1'b1;
    end else if (out_ready) begin
      full_q <= 1'b0;
    end
  end

  // One-entry buffer
  always_ff @(posedge clk) begin
    if (acc_valid) begin
      buf_q.data <= acc_data;
      buf_q.tag  <= acc_tag;
    end
  end

  // Output payload holds until the consumer takes it
  a_result_stable : assert property (
    @(posedge clk) disable iff (!resetn)
    out_valid && !out_ready |=> out_valid && $stable(out_result)
  ) else $error("result_stage: out_result changed while stalled");

endmodule

/* hdl/pe_array.sv */
`timescale 1ns/100ps
`include "conv_macros.svh"

module pe_array (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  op_valid,
  input  conv_pkg::pixel_col_t  op_pixels,
  input  conv_pkg::weight_row_t op_weights,
  input  conv_pkg::ctrl_t       op_ctrl,
  output logic                  stage_en,
  output logic                  acc_valid,
  output conv_pkg::acc_matrix_t acc_data,
  output conv_pkg::tag_t        acc_tag,
  input  logic                  buf_free
);

  localparam int ROWS      = `CONV_ROWS;
  localparam int COLS      = `CONV_COLS;
  localparam int DELAY_MUL = `CONV_DELAY_MUL;
  localparam int CTRL_W    = 1 + $bits(conv_pkg::ctrl_t);
  localparam int WEIGHT_W  = $bits(conv_pkg::weight_t);
  localparam int PROD_W    = $bits(conv_pkg::prod_t);

  logic                 held_q;
  logic                 acc_en;
  logic                 finish;
  logic [CTRL_W-1:0]    ctrl_pipe_q;
  logic                 mul_valid;
  conv_pkg::ctrl_t      mul_ctrl;
  conv_pkg::pixel_col_t pixel_q;
  conv_pkg::tag_t       tag_q;

  // Freeze everything only when a second result has nowhere to go
  assign stage_en  = !held_q || buf_free;
  assign acc_valid = held_q && buf_free;

  // Control pipe matches the operand path, DELAY_MUL enabled cycles
  mul_delay #(
    .N (DELAY_MUL),
    .W (CTRL_W)
  ) u_ctrl_delay (
    .clk    (clk),
    .resetn (resetn),
    .en     (stage_en),
    .d      ({op_valid, op_ctrl}),
    .q      (ctrl_pipe_q)
  );

  assign {mul_valid, mul_ctrl} = ctrl_pipe_q;
  assign acc_en = stage_en && mul_valid;
  assign finish = acc_en && mul_ctrl.last;

  // Input register for the shared pixel column
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pixel_q <= '0;
    end else if (stage_en) begin
      pixel_q <= op_pixels;
    end
  end

  for (genvar c = 0; c < COLS; c++) begin : g_col
    conv_pkg::weight_t weight_q;

    // Weight register, first multiplier stage
    mul_delay #(
      .N (1),
      .W (WEIGHT_W)
    ) u_weight_reg (
      .clk    (clk),
      .resetn (resetn),
      .en     (stage_en),
      .d      (op_weights[c]),
      .q      (weight_q)
    );

    for (genvar r = 0; r < ROWS; r++) begin : g_row
      conv_pkg::prod_t prod;
      conv_pkg::prod_t prod_q;
      conv_pkg::acc_t  prod_ext;
      conv_pkg::acc_t  acc_q;

      assign prod = $signed(pixel_q[r]) * $signed(weight_q);

      // Remaining multiplier latency
      mul_delay #(
        .N (DELAY_MUL-1),
        .W (PROD_W)
      ) u_prod_delay (
        .clk    (clk),
        .resetn (resetn),
        .en     (stage_en),
        .d      (prod),
        .q      (prod_q)
      );

      // Sign extend before accumulating
      assign prod_ext = conv_pkg::acc_t'(prod_q);

      // First beat of a packet overwrites the old sum
      always_ff @(posedge clk) begin
        if (!resetn) begin
          acc_q <= '0;
        end else if (acc_en) begin
          acc_q <= mul_ctrl.first ? prod_ext : acc_q + prod_ext;
        end
      end

      assign acc_data[c][r] = acc_q;
    end
  end

  // Set wins over clear, a new result may finish as the old one leaves
  always_ff @(posedge clk) begin
    if (!resetn) begin
      held_q <= 1'b0;
    end else if (finish) begin
      held_q <= 1'b1;
    end else if (acc_valid) begin
      held_q <= 1'b0;
    end
  end

  // Tag of the finished packet
  always_ff @(posedge clk) begin
    if (finish) begin
      tag_q <= mul_ctrl.tag;
    end
  end

  assign acc_tag = tag_q;

  // A finished matrix is never added to, the next beat must open a packet
  a_held_not_summed : assert property (
    @(posedge clk) disable iff (!resetn)
    acc_en && held_q |-> mul_ctrl.first
  ) else $error("pe_array: beat accumulated onto a finished result");

endmodule

/* hdl/beat_decode.sv */
`timescale 1ns/100ps

module beat_decode (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  in_valid,
  input  conv_pkg::beat_t       in_beat,
  output logic                  in_ready,
  output logic                  op_valid,
  output conv_pkg::pixel_col_t  op_pixels,
  output conv_pkg::weight_row_t op_weights,
  output conv_pkg::ctrl_t       op_ctrl,
  input  logic                  stage_en
);

  logic first_q;
  logic accept;

  // Handshake passes straight through to the array
  assign op_valid = in_valid;
  assign in_ready = stage_en;
  assign accept   = in_valid && stage_en;

  // Next accepted beat opens a packet after reset or after a last beat
  always_ff @(posedge clk) begin
    if (!resetn) begin
      first_q <= 1'b1;
    end else if (accept) begin
      first_q <= in_beat.last;
    end
  end

  // Same pixel column goes to every column of the array
  assign op_pixels  = in_beat.pixels;
  assign op_weights = in_beat.weights;

  always_comb begin
    op_ctrl       = '0;
    op_ctrl.first = first_q;
    op_ctrl.last  = in_beat.last;
    op_ctrl.tag   = in_beat.tag;
  end

  // A stalled beat must not change under the sender's hand
  a_beat_stable : assert property (
    @(posedge clk) disable iff (!resetn)
    in_valid && !in_ready |=> !in_valid || $stable(in_beat)
  ) else $error("beat_decode: in_beat changed while stalled");

endmodule

/* hdl/mul_delay.sv */
`timescale 1ns/100ps

module mul_delay #(
  parameter int N = 2,
  parameter int W = 8
) (
  input  logic         clk,
  input  logic         resetn,
  input  logic         en,
  input  logic [W-1:0] d,
  output logic [W-1:0] q
);

  // Stage 0 takes the input, stage N-1 drives the output
  logic [N-1:0][W-1:0] stages;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      stages <= '0;
    end else if (en) begin
      stages[0] <= d;
      for (int i = 1; i < N; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign q = stages[N-1];

endmodule

/* hdl/conv_pkg.sv */
`include "conv_macros.svh"

package conv_pkg;

  // Scalar operand and result types
  typedef logic signed [`CONV_X_BITS-1:0] pixel_t;
  typedef logic signed [`CONV_K_BITS-1:0] weight_t;
  typedef logic signed [`CONV_X_BITS+`CONV_K_BITS-1:0] prod_t;
  typedef logic signed [`CONV_Y_BITS-1:0] acc_t;
  typedef logic [`CONV_TAG_BITS-1:0] tag_t;

  // Broadcast vectors and the output matrix, indexed [c][r]
  typedef pixel_t [`CONV_ROWS-1:0] pixel_col_t;
  typedef weight_t [`CONV_COLS-1:0] weight_row_t;
  typedef acc_t [`CONV_COLS-1:0][`CONV_ROWS-1:0] acc_matrix_t;

  // Input stream payload
  typedef struct packed {
    pixel_col_t  pixels;
    weight_row_t weights;
    tag_t        tag;
    logic        last;
  } beat_t;

  // Per-beat control riding along with the operands
  typedef struct packed {
    logic first;
    logic last;
    tag_t tag;
  } ctrl_t;

  // Output stream payload
  typedef struct packed {
    acc_matrix_t data;
    tag_t        tag;
  } result_t;

endpackage

/* hdl/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Array shape
`define CONV_ROWS 4
`define CONV_COLS 4

// Operand and accumulator widths
`define CONV_X_BITS 8
`define CONV_K_BITS 8
`define CONV_Y_BITS 24

// Multiplier pipeline depth, 2 or more
`define CONV_DELAY_MUL 3

// Packet tag width
`define CONV_TAG_BITS 4

`endif
